//--- cpu_consts.svh
// cpu constants
// word size, register count, microcode address width and the
// fixed microcode entry points shared by the core and its packages
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath
`define DATA_W   16     // full word
`define BYTE_W   8      // byte operand size
`define NREGS    4      // general registers

// microcode
`define UADDR_W  8      // opcode nibble + step nibble
`define FETCH_UA 8'h00  // first fetch after reset
`define ERR_UA   8'hF0  // trap for unknown opcodes

`endif

//--- cpu_pkg.sv
// cpu architectural types
// data words, flags, register numbers, operand size and the
// sixteen condition codes tested by jumps
`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`DATA_W-1:0] data_t;

    typedef logic [$clog2(`NREGS)-1:0] reg_idx_t;

    // flag byte layout
    typedef struct packed {
        logic       s;        // sign
        logic       z;        // zero
        logic [2:0] rsv_hi;
        logic       v;        // overflow
        logic       rsv_lo;
        logic       c;        // carry, borrow on sub
    } flags_t;

    typedef enum logic {
        SZ_BYTE,
        SZ_WORD
    } size_t;

    // order matches md[3:0] of the jump instruction
    typedef enum logic [3:0] {
        CC_F,     // never
        CC_LT,    // signed <
        CC_LE,    // signed <=
        CC_ULE,   // unsigned <=
        CC_OV,
        CC_MI,
        CC_EQ,
        CC_C,
        CC_T,     // always
        CC_GE,    // signed >=
        CC_GT,    // signed >
        CC_UGT,   // unsigned >
        CC_NOV,
        CC_PL,
        CC_NE,
        CC_NC
    } cond_t;

endpackage

//--- ucode_pkg.sv
// microinstruction field types
// encodings for the microcode address, size control, loop control,
// ALU operation and ALU B operand select
`include "cpu_consts.svh"

package ucode_pkg;

    // upper nibble is the opcode page, lower nibble the step
    typedef logic [`UADDR_W-1:0] uaddr_t;

    // operand size control
    typedef enum logic [2:0] {
        SETW_NONE,
        SETW_BYTE,     // working size only
        SETW_WORD,     // working size only
        SETW_FROM_MD,  // working and saved size from md[0]
        SETW_WIDEN,
        SETW_SHORTEN,
        SETW_RELOAD    // back to the saved size
    } setw_t;

    // microcode loop control
    typedef enum logic [1:0] {
        LOOP_NONE,
        LOOP_SET,  // remember the following step
        LOOP_NZ    // go back there while the counter is not zero
    } loop_t;

    typedef enum logic [2:0] {
        ALU_PASS,  // result is the B operand
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR
    } alu_op_t;

    // ALU B operand
    typedef enum logic {
        OPND_IMM,
        OPND_REG
    } opnd_t;

endpackage

//--- mc_ctrl.sv
// microsequencer control block
// steps through the microcode, decodes opcodes into microcode pages,
// evaluates jump conditions, keeps the operand size and the program
// counter, and stops for good on halt or an unknown opcode
`timescale 1ns/1ps
`include "cpu_consts.svh"

module mc_ctrl import cpu_pkg::*, ucode_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic [23:0] instr,     // opcode byte + immediate
    input  flags_t   flags,
    input  logic     cnt_zero,
    // microcode fields
    input  logic     ni,
    input  setw_t    setw_sel,
    input  loop_t    loop_sel,
    input  logic     jp,
    input  logic     halt_en,
    output uaddr_t   uaddr,
    output data_t    pc,
    output size_t    size,
    output reg_idx_t dst,
    output reg_idx_t src,
    output data_t    imm,
    output logic     cc,
    output logic     halt,
    output logic     dec_err
);

    localparam logic [3:0] LAST_OP = 4'hB;  // HALT is the highest valid opcode

    logic [7:0] md;         // current opcode byte
    size_t      saved_size;
    logic [3:0] loop_ret;   // step to return to
    logic [3:0] nx_step;
    logic       stop;
    logic       run;

    assign nx_step = uaddr[3:0] + 4'd1;
    assign stop    = halt | dec_err;
    assign run     = !hold && !stop;
    assign dst     = md[1:0];
    assign src     = md[3:2];

    // condition from flags, selected by the low opcode nibble
    always_comb begin
        case (cond_t'(md[3:0]))
            CC_F:    cc = 1'b0;
            CC_LT:   cc = flags.s ^ flags.v;
            CC_LE:   cc = flags.z | (flags.s ^ flags.v);
            CC_ULE:  cc = flags.z | flags.c;
            CC_OV:   cc = flags.v;
            CC_MI:   cc = flags.s;
            CC_EQ:   cc = flags.z;
            CC_C:    cc = flags.c;
            CC_T:    cc = 1'b1;
            CC_GE:   cc = ~(flags.s ^ flags.v);
            CC_GT:   cc = ~(flags.z | (flags.s ^ flags.v));
            CC_UGT:  cc = ~(flags.z | flags.c);
            CC_NOV:  cc = ~flags.v;
            CC_PL:   cc = ~flags.s;
            CC_NE:   cc = ~flags.z;
            default: cc = ~flags.c;  // CC_NC
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            uaddr      <= `FETCH_UA;
            pc         <= '0;
            md         <= '0;
            imm        <= '0;
            size       <= SZ_WORD;
            saved_size <= SZ_WORD;
            loop_ret   <= '0;
            halt       <= 1'b0;
            dec_err    <= 1'b0;
        end else if (run) begin
            case (setw_sel)
                SETW_BYTE, SETW_SHORTEN: size <= SZ_BYTE;
                SETW_WORD, SETW_WIDEN:   size <= SZ_WORD;
                SETW_FROM_MD: begin
                    size       <= md[0] ? SZ_WORD : SZ_BYTE;
                    saved_size <= md[0] ? SZ_WORD : SZ_BYTE;
                end
                SETW_RELOAD:  size <= saved_size;
                default: ;
            endcase

            if (loop_sel == LOOP_SET) begin
                loop_ret <= nx_step;  // loop body starts after this step
            end

            if (halt_en) begin
                halt <= 1'b1;  // stay on this step
            end else if (loop_sel == LOOP_NZ && !cnt_zero) begin
                uaddr[3:0] <= loop_ret;
            end else if (ni) begin
                md  <= instr[23:16];
                imm <= instr[15:0];
                pc  <= pc + 1'b1;
                if (instr[23:20] > LAST_OP) begin
                    uaddr   <= `ERR_UA;
                    dec_err <= 1'b1;
                end else begin
                    uaddr <= {instr[23:20], 4'h0};  // opcode page
                end
            end else begin
                uaddr[3:0] <= nx_step;
            end

            // taken jump, the next ni fetches from the target
            if (jp && cc) begin
                pc <= imm;
            end
        end
    end

endmodule

//--- mc_rom.sv
// microcode ROM
// maps a microcode address to its control fields; every opcode page
// ends in a step with ni, unlisted addresses give ni alone
`timescale 1ns/1ps
`include "cpu_consts.svh"

module mc_rom import ucode_pkg::*; (
    input  uaddr_t  uaddr,
    output logic    ni,
    output setw_t   setw_sel,
    output loop_t   loop_sel,
    output alu_op_t alu_sel,
    output opnd_t   opnd_sel,
    output logic    flag_we,
    output logic    reg_we,
    output logic    cnt_ld,
    output logic    cnt_dec,
    output logic    jp,
    output logic    out_en,
    output logic    halt_en
);

    always_comb begin
        ni       = 1'b0;
        setw_sel = SETW_NONE;
        loop_sel = LOOP_NONE;
        alu_sel  = ALU_PASS;
        opnd_sel = OPND_IMM;
        flag_we  = 1'b0;
        reg_we   = 1'b0;
        cnt_ld   = 1'b0;
        cnt_dec  = 1'b0;
        jp       = 1'b0;
        out_en   = 1'b0;
        halt_en  = 1'b0;
        case (uaddr)
            // fetch and the last step of each page, also NOP
            `FETCH_UA, 8'h11, 8'h21, 8'h31, 8'h41, 8'h51, 8'h61,
            8'h73, 8'h81, 8'h91, 8'hA1: begin
                ni       = 1'b1;
                setw_sel = SETW_RELOAD;
            end
            8'h10: begin  // LDI
                alu_sel  = ALU_PASS;
                reg_we   = 1'b1;
            end
            8'h20: begin  // ADD
                alu_sel  = ALU_ADD;
                reg_we   = 1'b1;
                flag_we  = 1'b1;
            end
            8'h30: begin  // SUB
                alu_sel  = ALU_SUB;
                reg_we   = 1'b1;
                flag_we  = 1'b1;
            end
            8'h40: begin  // AND
                alu_sel  = ALU_AND;
                reg_we   = 1'b1;
                flag_we  = 1'b1;
            end
            8'h50: begin  // XOR
                alu_sel  = ALU_XOR;
                reg_we   = 1'b1;
                flag_we  = 1'b1;
            end
            8'h60: begin  // CMP, flags only
                alu_sel  = ALU_SUB;
                flag_we  = 1'b1;
            end
            // MUL: dst = src, then dst - src clears it, then n adds of src
            8'h70: begin
                alu_sel  = ALU_PASS;
                opnd_sel = OPND_REG;
                reg_we   = 1'b1;
                cnt_ld   = 1'b1;     // count from imm
            end
            8'h71: begin
                alu_sel  = ALU_SUB;
                opnd_sel = OPND_REG;
                reg_we   = 1'b1;
                cnt_dec  = 1'b1;
                loop_sel = LOOP_SET;  // body is step 2
            end
            8'h72: begin
                alu_sel  = ALU_ADD;
                opnd_sel = OPND_REG;
                reg_we   = 1'b1;
                flag_we  = 1'b1;
                cnt_dec  = 1'b1;
                loop_sel = LOOP_NZ;
            end
            8'h80: setw_sel = SETW_FROM_MD;  // SETW
            8'h90: jp       = 1'b1;          // JP cc
            8'hA0: out_en   = 1'b1;          // OUT
            8'hB0: halt_en  = 1'b1;          // HALT
            default: ni = 1'b1;
        endcase
    end

endmodule

//--- mc_alu.sv
// arithmetic and logic unit
// computes at byte or word size, upper byte cleared in byte size,
// flags taken at the active width
`timescale 1ns/1ps
`include "cpu_consts.svh"

module mc_alu import cpu_pkg::*, ucode_pkg::*; (
    input  data_t   a,
    input  data_t   b,
    input  alu_op_t op,
    input  size_t   size,
    output data_t   result,
    output flags_t  flags_out
);

    localparam int HI_W = `DATA_W - `BYTE_W;

    logic             byte_sz;
    data_t            am;
    data_t            bm;
    logic [`DATA_W:0] sum;   // top bit is the word carry
    logic             msb_a;
    logic             msb_b;
    logic             msb_r;
    logic             cout;

    assign byte_sz = (size == SZ_BYTE);
    assign am      = byte_sz ? {{HI_W{1'b0}}, a[`BYTE_W-1:0]} : a;
    assign bm      = byte_sz ? {{HI_W{1'b0}}, b[`BYTE_W-1:0]} : b;

    always_comb begin
        case (op)
            ALU_ADD: sum = {1'b0, am} + {1'b0, bm};
            ALU_SUB: sum = {1'b0, am} - {1'b0, bm};
            ALU_AND: sum = {1'b0, am & bm};
            ALU_XOR: sum = {1'b0, am ^ bm};
            default: sum = {1'b0, bm};  // pass
        endcase
    end

    assign result = byte_sz ? {{HI_W{1'b0}}, sum[`BYTE_W-1:0]} : sum[`DATA_W-1:0];
    assign msb_a  = byte_sz ? am[`BYTE_W-1] : am[`DATA_W-1];
    assign msb_b  = byte_sz ? bm[`BYTE_W-1] : bm[`DATA_W-1];
    assign msb_r  = byte_sz ? sum[`BYTE_W-1] : sum[`DATA_W-1];
    assign cout   = byte_sz ? sum[`BYTE_W] : sum[`DATA_W];  // borrow on sub

    always_comb begin
        flags_out   = '0;
        flags_out.s = msb_r;
        flags_out.z = (result == '0);
        case (op)
            ALU_ADD: begin
                flags_out.c = cout;
                flags_out.v = (msb_a == msb_b) && (msb_r != msb_a);
            end
            ALU_SUB: begin
                flags_out.c = cout;
                flags_out.v = (msb_a != msb_b) && (msb_r != msb_a);
            end
            default: ;  // logic ops clear c and v
        endcase
    end

endmodule

//--- mc_regs.sv
// register file
// four general registers, the flag register and the microcode loop
// counter; byte writes keep the upper byte of the register
`timescale 1ns/1ps
`include "cpu_consts.svh"

module mc_regs import cpu_pkg::*, ucode_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  reg_idx_t dst,
    input  reg_idx_t src,
    input  opnd_t    opnd_sel,
    input  data_t    imm,
    input  size_t    size,
    input  data_t    result,
    input  flags_t   flags_in,
    input  logic     reg_we,
    input  logic     flag_we,
    input  logic     cnt_ld,
    input  logic     cnt_dec,
    output data_t    a,
    output data_t    b,
    output flags_t   flags,
    output logic     cnt_zero
);

    data_t regs [`NREGS];
    data_t cnt;       // loop counter
    data_t b_raw;

    function automatic data_t fit(data_t v, size_t sz);
        return (sz == SZ_BYTE) ? {{(`DATA_W-`BYTE_W){1'b0}}, v[`BYTE_W-1:0]} : v;
    endfunction

    assign b_raw    = (opnd_sel == OPND_REG) ? regs[src] : imm;
    assign a        = fit(regs[dst], size);
    assign b        = fit(b_raw, size);
    assign cnt_zero = (cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
            flags <= '0;
            cnt   <= '0;
        end else if (!hold) begin
            if (reg_we) begin
                if (size == SZ_BYTE) begin
                    regs[dst][`BYTE_W-1:0] <= result[`BYTE_W-1:0];
                end else begin
                    regs[dst] <= result;
                end
            end
            if (flag_we) begin
                flags <= flags_in;
            end
            if (cnt_ld) begin
                cnt <= imm;
            end else if (cnt_dec && !cnt_zero) begin
                cnt <= cnt - 1'b1;  // stops at zero
            end
        end
    end

endmodule

//--- mc_core.sv
// microcoded processor core
// control block, microcode ROM, ALU and register file; instructions
// arrive as 24-bit words for the current pc
`timescale 1ns/1ps

module mc_core import cpu_pkg::*, ucode_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        hold,
    input  logic [23:0] instr,
    output data_t       pc,
    output logic        out_strobe,
    output data_t       out_data,
    output logic        halt,
    output logic        dec_err
);

    uaddr_t   uaddr;
    size_t    size;
    reg_idx_t dst;
    reg_idx_t src;
    data_t    imm;
    data_t    a;
    data_t    b;
    data_t    result;
    flags_t   flags;
    flags_t   alu_flags;
    logic     cnt_zero;
    // microcode fields
    logic     ni;
    setw_t    setw_sel;
    loop_t    loop_sel;
    alu_op_t  alu_sel;
    opnd_t    opnd_sel;
    logic     flag_we;
    logic     reg_we;
    logic     cnt_ld;
    logic     cnt_dec;
    logic     jp;
    logic     out_en;
    logic     halt_en;

    assign out_strobe = out_en & ~hold;
    assign out_data   = a;  // destination, already fitted to size

    mc_ctrl ctrl_i (
        .clk, .rst, .hold, .instr, .flags, .cnt_zero,
        .ni, .setw_sel, .loop_sel, .jp, .halt_en,
        .uaddr, .pc, .size, .dst, .src, .imm,
        .cc      (),
        .halt, .dec_err
    );

    mc_rom rom_i (
        .uaddr, .ni, .setw_sel, .loop_sel, .alu_sel, .opnd_sel,
        .flag_we, .reg_we, .cnt_ld, .cnt_dec, .jp, .out_en, .halt_en
    );

    mc_alu alu_i (
        .a, .b,
        .op        (alu_sel),
        .size,
        .result,
        .flags_out (alu_flags)
    );

    mc_regs regs_i (
        .clk, .rst, .hold, .dst, .src, .opnd_sel, .imm, .size, .result,
        .flags_in  (alu_flags),
        .reg_we, .flag_we, .cnt_ld, .cnt_dec,
        .a, .b, .flags, .cnt_zero
    );

endmodule

//--- tb_mc_core.sv
// testbench for the microcoded core
// runs a table of small programs, each from a fresh reset, under random
// hold, and checks the OUT values and the final pc, halt and dec_err state
`timescale 1ns/1ps

module tb_mc_core import cpu_pkg::*; ();

    localparam int MAXT = 96;   // table capacity
    localparam int PLEN = 16;   // words per program

    logic        clk;
    logic        rst;
    logic        hold;
    logic [23:0] instr;
    data_t       pc;
    logic        out_strobe;
    data_t       out_data;
    logic        halt;
    logic        dec_err;

    logic [23:0] prog [MAXT][PLEN];
    data_t       expo [MAXT][PLEN];   // expected OUT values in order
    int          nexp [MAXT];
    logic        exp_halt [MAXT];
    logic        exp_err [MAXT];
    data_t       exp_pc [MAXT];       // pc once the core has stopped
    int          ntests;
    int          pw;                  // write position in current program
    int          cur;
    logic        built;

    // compare values and condition masks, bit n set when cond n is taken
    data_t       cx [5];
    data_t       cy [5];
    logic [15:0] cmask [5];

    mc_core dut_i (
        .clk, .rst, .hold, .instr, .pc, .out_strobe, .out_data, .halt, .dec_err
    );

    // instruction word served for the current pc, halt past the end
    assign instr = (pc < PLEN) ? prog[cur][pc[3:0]] : 24'hB00000;

    always #2 clk = ~clk;

    task automatic fail_now();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("[ERROR] test %0d %s: got %h, expected %h", cur, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] test %0d %s: got %h, expected %h", cur, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] test %0d %s: got %h, expected %h", cur, name, got, exp);
            fail_now();
        end
    endtask

    task automatic new_prog();
        ntests++;
        pw = 0;
        nexp[ntests-1] = 0;
        for (int i = 0; i < PLEN; i++) begin
            prog[ntests-1][i] = 24'hB00000;  // unused words halt
        end
    endtask

    task automatic put(input logic [7:0] md, input logic [15:0] imm);
        prog[ntests-1][pw] = {md, imm};
        pw++;
    endtask

    task automatic expect_out(input data_t v);
        expo[ntests-1][nexp[ntests-1]] = v;
        nexp[ntests-1]++;
    endtask

    task automatic expect_end(input logic h, input logic e, input data_t p);
        exp_halt[ntests-1] = h;
        exp_err[ntests-1]  = e;
        exp_pc[ntests-1]   = p;
    endtask

    task automatic build_table();
        ntests = 0;
        // word arithmetic with 16-bit wrap
        new_prog();
        put(8'h10, 16'h1234); put(8'h20, 16'hF000); put(8'hA0, 16'h0);
        put(8'h11, 16'h0005); put(8'h31, 16'h0007); put(8'hA1, 16'h0);
        put(8'h12, 16'hFF0F); put(8'h42, 16'h0FF0); put(8'hA2, 16'h0);
        put(8'h52, 16'hFFFF); put(8'hA2, 16'h0); put(8'h00, 16'h0);
        put(8'hB0, 16'h0);
        expect_out(16'h0234); expect_out(16'hFFFE); expect_out(16'h0F00);
        expect_out(16'hF0FF); expect_end(1'b1, 1'b0, 16'd13);
        // byte size keeps the upper byte, OUT masked to the size
        new_prog();
        put(8'h10, 16'h12F0); put(8'h80, 16'h0); put(8'h20, 16'h0020);
        put(8'hA0, 16'h0); put(8'h30, 16'h0011); put(8'hA0, 16'h0);
        put(8'h11, 16'hABCD); put(8'h81, 16'h0); put(8'hA0, 16'h0);
        put(8'hA1, 16'h0); put(8'hB0, 16'h0);
        expect_out(16'h0010); expect_out(16'h00FF); expect_out(16'h12FF);
        expect_out(16'h00CD); expect_end(1'b1, 1'b0, 16'd11);
        // MUL r0 = r1 * n, word size
        new_prog();
        put(8'h11, 16'h1234);
        for (int n = 1; n <= 5; n++) begin
            put(8'h74, 16'(n));
            put(8'hA0, 16'h0);
        end
        put(8'hB0, 16'h0);
        expect_out(16'h1234); expect_out(16'h2468); expect_out(16'h369C);
        expect_out(16'h48D0); expect_out(16'h5B04); expect_end(1'b1, 1'b0, 16'd12);
        // MUL at byte size
        new_prog();
        put(8'h11, 16'h0037); put(8'h80, 16'h0); put(8'h74, 16'd5);
        put(8'hA0, 16'h0); put(8'h74, 16'd3); put(8'hA0, 16'h0);
        put(8'hB0, 16'h0);
        expect_out(16'h0013); expect_out(16'h00A5); expect_end(1'b1, 1'b0, 16'd7);
        // unknown opcodes trap, later OUT never runs
        for (int op = 12; op < 16; op++) begin
            new_prog();
            put(8'h10, 16'h0055); put(8'hA0, 16'h0);
            put({4'(op), 4'h0}, 16'h0); put(8'hA0, 16'h0);
            expect_out(16'h0055); expect_end(1'b0, 1'b1, 16'd3);
        end
        // every condition after each compare, OUT only when not taken
        cx[0] = 16'h0005; cy[0] = 16'h0005; cmask[0] = 16'hB34C;  // equal
        cx[1] = 16'h0003; cy[1] = 16'h0005; cmask[1] = 16'h51AE;  // less
        cx[2] = 16'h0005; cy[2] = 16'h0003; cmask[2] = 16'hFF00;  // greater
        cx[3] = 16'h8000; cy[3] = 16'h0001; cmask[3] = 16'hE916;  // overflow
        cx[4] = 16'h7FFF; cy[4] = 16'hFFFF; cmask[4] = 16'h47B8;  // overflow, borrow
        for (int p = 0; p < 5; p++) begin
            for (int c = 0; c < 16; c++) begin
                new_prog();
                put(8'h10, cx[p]); put(8'h60, cy[p]);
                put({4'h9, 4'(c)}, 16'd4);  // skip the OUT when taken
                put(8'hA0, 16'h0); put(8'hB0, 16'h0);
                if (!cmask[p][c]) begin
                    expect_out(cx[p]);
                end
                expect_end(1'b1, 1'b0, 16'd5);  // both paths end on the HALT
            end
        end
    endtask

    task automatic run_prog(input int t);
        int nout;
        int extra;
        @(negedge clk);
        cur  = t;
        rst  = 1'b1;
        hold = 1'b0;
        repeat (8) @(negedge clk);
        // state held by reset
        check_data("pc", pc, 16'h0000);
        check_bit("out_strobe", out_strobe, 1'b0);
        check_bit("halt", halt, 1'b0);
        check_bit("dec_err", dec_err, 1'b0);
        rst   = 1'b0;
        nout  = 0;
        extra = 0;
        while (extra < 8) begin   // a few cycles past the stop
            @(negedge clk);
            hold = ($urandom % 4) == 0;
            #1;
            if (out_strobe) begin
                if (nout < nexp[t]) begin
                    check_data("out_data", out_data, expo[t][nout]);
                end
                nout++;
            end
            if (halt || dec_err) begin
                extra++;
            end
        end
        check_count("out pulses", nout, nexp[t]);
        check_bit("halt", halt, exp_halt[t]);
        check_bit("dec_err", dec_err, exp_err[t]);
        check_data("pc", pc, exp_pc[t]);
    endtask

    // watchdog sized from the table
    initial begin
        wait (built);
        #(ntests * 200 * 4);
        $display("timeout: the core never reached its end state");
        fail_now();
    end

    initial begin
        clk   = 1'b0;
        rst   = 1'b1;
        hold  = 1'b0;
        cur   = 0;
        built = 1'b0;
        void'($urandom(57290));
        build_table();
        built = 1'b1;
        for (int t = 0; t < ntests; t++) begin
            run_prog(t);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- src.f
+incdir+.
cpu_pkg.sv
ucode_pkg.sv
mc_ctrl.sv
mc_rom.sv
mc_alu.sv
mc_regs.sv
mc_core.sv
tb_mc_core.sv

//--- Makefile
# Verilator build and run for the microcoded core testbench

VERILATOR ?= verilator
TOP       ?= tb_mc_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
